// ==== compile.f ====
rtl/dsp_pkg.sv
rtl/axis_splitter.sv
rtl/axis_fir.sv
rtl/axis_dac_round.sv
rtl/dsp_chain_top.sv
verif/dsp_chain_checker.sv
verif/tb_dsp_chain.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DSP chain testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_dsp_chain -Mdir "$OBJ_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== verif/tb_dsp_chain.sv ====
`timescale 1ns/1ps

module tb_dsp_chain;

    import dsp_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_ROWS        = 24;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;
    // Gap code for a random hold-off of 0 to 3 cycles
    localparam logic [3:0] GAP_RAND = 4'hf;

    // Sample with its hold-off and random ready flags for monitor and DAC
    typedef struct packed {
        logic signed [ADC_WIDTH-1:0] sample;
        logic [3:0]                  gap;
        logic                        mon_rand;
        logic                        dac_rand;
    } stim_row_t;

    localparam stim_row_t STIM [NUM_ROWS] = '{
        // Small values into a zeroed delay line and negative rounding
        '{14'sd100,   4'd0,     1'b0, 1'b0},
        '{-14'sd1,    4'd0,     1'b0, 1'b0},
        '{-14'sd3,    4'd1,     1'b0, 1'b0},
        '{14'sd2,     4'd0,     1'b0, 1'b0},
        // Full scale positive then negative
        '{14'sd8191,  4'd0,     1'b0, 1'b0},
        '{14'sd8191,  4'd0,     1'b0, 1'b0},
        '{14'sd8191,  4'd0,     1'b0, 1'b0},
        '{14'sd8191,  4'd0,     1'b0, 1'b0},
        '{14'h2000,   4'd0,     1'b0, 1'b0},
        '{14'h2000,   4'd0,     1'b0, 1'b0},
        '{14'h2000,   4'd0,     1'b0, 1'b0},
        '{14'h2000,   4'd0,     1'b0, 1'b0},
        '{14'sd8191,  4'd2,     1'b0, 1'b0},
        '{-14'sd5,    4'd0,     1'b0, 1'b0},
        '{-14'sd7,    4'd3,     1'b0, 1'b0},
        // Back-pressure on one output and then on both
        '{14'sd1234,  GAP_RAND, 1'b1, 1'b0},
        '{-14'sd4321, 4'd0,     1'b1, 1'b0},
        '{-14'sd2,    4'd0,     1'b0, 1'b1},
        '{14'sd3000,  GAP_RAND, 1'b0, 1'b1},
        '{-14'sd8000, 4'd0,     1'b0, 1'b1},
        '{14'sd8191,  GAP_RAND, 1'b1, 1'b1},
        '{14'h2000,   4'd0,     1'b1, 1'b1},
        '{-14'sd999,  GAP_RAND, 1'b1, 1'b1},
        '{14'sd511,   4'd0,     1'b1, 1'b1}
    };

    logic          a_clk;
    logic          reset;
    adc_stream_t   s_adc;
    logic          s_adc_valid;
    logic          s_adc_ready;
    lane_stream_t  m_mon;
    logic          m_mon_valid;
    logic          m_mon_ready;
    dac_stream_t   m_dac;
    logic          m_dac_valid;
    logic          m_dac_ready;
    logic          mon_rand;
    logic          dac_rand;
    integer        seed = 32'h1d8d_d17a;
    int            value_errors;
    int            other_errors;
    int            delivered;
    int            pending;

    dsp_chain_top u_dut (
        .a_clk       (a_clk),
        .reset       (reset),
        .s_adc       (s_adc),
        .s_adc_valid (s_adc_valid),
        .s_adc_ready (s_adc_ready),
        .m_mon       (m_mon),
        .m_mon_valid (m_mon_valid),
        .m_mon_ready (m_mon_ready),
        .m_dac       (m_dac),
        .m_dac_valid (m_dac_valid),
        .m_dac_ready (m_dac_ready)
    );

    dsp_chain_checker u_checker (
        .a_clk        (a_clk),
        .reset        (reset),
        .s_adc        (s_adc),
        .s_adc_valid  (s_adc_valid),
        .s_adc_ready  (s_adc_ready),
        .m_mon        (m_mon),
        .m_mon_valid  (m_mon_valid),
        .m_mon_ready  (m_mon_ready),
        .m_dac        (m_dac),
        .m_dac_valid  (m_dac_valid),
        .m_dac_ready  (m_dac_ready),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .delivered    (delivered),
        .pending      (pending)
    );

    ////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////

    initial begin
        a_clk = 1'b0;
        forever #(CLK_PERIOD / 2) a_clk = ~a_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before all samples came out");
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // New ready levels on the falling edge
    task automatic next_cycle();
        @(negedge a_clk);
        m_mon_ready = mon_rand ? (($random(seed) & 3) != 0) : 1'b1;
        m_dac_ready = dac_rand ? (($random(seed) & 3) != 0) : 1'b1;
    endtask

    // Hold the sample until the DUT takes it
    task automatic send_sample(input logic signed [ADC_WIDTH-1:0] sample);
        logic taken;
        taken = 1'b0;
        s_adc.data  = sample;
        s_adc_valid = 1'b1;
        while (!taken) begin
            @(posedge a_clk);
            taken = s_adc_ready;
            next_cycle();
        end
        s_adc_valid = 1'b0;
    endtask

    initial begin
        stim_row_t row;
        int        gap;
        int        tb_errors;
        tb_errors   = 0;
        reset       = 1'b1;
        s_adc       = '0;
        s_adc_valid = 1'b0;
        m_mon_ready = 1'b1;
        m_dac_ready = 1'b1;
        mon_rand    = 1'b0;
        dac_rand    = 1'b0;
        repeat (RESET_CYCLES) @(negedge a_clk);
        reset = 1'b0;
        // Idle cycle so the valids can be seen low after reset
        next_cycle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            row      = STIM[r];
            mon_rand = row.mon_rand;
            dac_rand = row.dac_rand;
            gap      = (row.gap == GAP_RAND) ? int'($unsigned($random(seed)) % 4) : int'(row.gap);
            repeat (gap) next_cycle();
            send_sample(row.sample);
        end
        // Drain with both outputs ready
        mon_rand = 1'b0;
        dac_rand = 1'b0;
        while (pending != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        if (delivered != NUM_ROWS) begin
            $display("ERROR: %0d DAC samples delivered, %0d sent", delivered, NUM_ROWS);
            tb_errors++;
        end
        $display("errors: value %0d, other %0d, testbench %0d",
                 value_errors, other_errors, tb_errors);
        if (value_errors + other_errors + tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/dsp_chain_checker.sv ====
`timescale 1ns/1ps

module dsp_chain_checker (
    input  logic                  a_clk,
    input  logic                  reset,
    // ADC side of the DUT
    input  dsp_pkg::adc_stream_t  s_adc,
    input  logic                  s_adc_valid,
    input  logic                  s_adc_ready,
    // Monitor and DAC outputs
    input  dsp_pkg::lane_stream_t m_mon,
    input  logic                  m_mon_valid,
    input  logic                  m_mon_ready,
    input  dsp_pkg::dac_stream_t  m_dac,
    input  logic                  m_dac_valid,
    input  logic                  m_dac_ready,
    // Results for the testbench top
    output int                    value_errors,
    output int                    other_errors,
    output int                    delivered,
    output int                    pending
);

    import dsp_pkg::*;

    typedef enum {ERR_VALUE, ERR_OTHER} err_kind_t;

    // Model delay line with the newest sample at index 0
    longint hist [NUM_TAPS];
    longint mon_q [$];
    longint dac_q [$];
    // Acceptance cycle of each DAC entry
    longint cyc_q [$];
    longint cyc = 0;
    longint last_dac_low = -1;
    longint mon_held = 0;
    longint dac_held = 0;
    logic   mon_hold = 1'b0;
    logic   dac_hold = 1'b0;
    logic   reset_d = 1'b0;
    int     n_value = 0;
    int     n_other = 0;
    int     n_delivered = 0;
    int     n_pending = 0;

    assign value_errors = n_value;
    assign other_errors = n_other;
    assign delivered    = n_delivered;
    assign pending      = n_pending;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic longint round_to_dac(longint sum);
        longint q;
        longint dac_max;
        dac_max = (longint'(1) << (DAC_WIDTH - 1)) - 1;
        // Integer division truncates toward zero
        q = sum / (longint'(1) << COEF_FRAC);
        q = q / (longint'(1) << (DATA_WIDTH - DAC_WIDTH));
        if (q > dac_max) begin
            q = dac_max;
        end else if (q < -dac_max - 1) begin
            q = -dac_max - 1;
        end
        return q;
    endfunction

    task automatic log_error(err_kind_t kind);
        if (kind == ERR_VALUE) begin
            n_value++;
        end else begin
            n_other++;
        end
    endtask

    task automatic value_error(string name, longint exp_val, longint act_val);
        $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
        log_error(ERR_VALUE);
    endtask

    task automatic other_error(string what);
        $display("ERROR at %0t ns: %s", $time, what);
        log_error(ERR_OTHER);
    endtask

    ////////////////////////////////////////
    // Port watching
    ////////////////////////////////////////

    always @(posedge a_clk) begin
        longint exp_val;
        longint acc_cyc;
        longint sum;
        cyc++;
        // Valids cleared by reset
        if (reset_d && (m_mon_valid || m_dac_valid)) begin
            other_error("valid output high during or right after reset");
        end
        if (reset) begin
            foreach (hist[i]) begin
                hist[i] = 0;
            end
            mon_q.delete();
            dac_q.delete();
            cyc_q.delete();
            mon_hold = 1'b0;
            dac_hold = 1'b0;
        end else begin
            // Broadcast moves in lockstep with the ADC input
            if ((s_adc_valid && s_adc_ready) != (m_mon_valid && m_mon_ready)) begin
                other_error("monitor transfer out of step with ADC acceptance");
            end
            if (s_adc_valid && s_adc_ready) begin
                for (int i = NUM_TAPS - 1; i > 0; i--) begin
                    hist[i] = hist[i-1];
                end
                // Left-justify with zero fill
                hist[0] = longint'(s_adc.data) * (longint'(1) << (DATA_WIDTH - ADC_WIDTH));
                sum = 0;
                for (int i = 0; i < NUM_TAPS; i++) begin
                    sum += longint'(fir_coefs[i]) * hist[i];
                end
                mon_q.push_back(hist[0]);
                dac_q.push_back(round_to_dac(sum));
                cyc_q.push_back(cyc);
            end
            // Stalled outputs hold their data
            if (mon_hold && m_mon_valid && longint'(m_mon.data) != mon_held) begin
                value_error("m_mon while stalled", mon_held, m_mon.data);
            end
            if (dac_hold && !m_dac_valid) begin
                other_error("m_dac_valid dropped before its transfer");
            end else if (dac_hold && longint'(m_dac.data) != dac_held) begin
                value_error("m_dac while stalled", dac_held, m_dac.data);
            end
            if (m_mon_valid && m_mon_ready) begin
                if (mon_q.size() == 0) begin
                    other_error("monitor output with no accepted sample behind it");
                end else begin
                    exp_val = mon_q.pop_front();
                    if (longint'(m_mon.data) != exp_val) begin
                        value_error("m_mon", exp_val, m_mon.data);
                    end
                end
            end
            if (m_dac_valid && m_dac_ready) begin
                n_delivered++;
                if (dac_q.size() == 0) begin
                    other_error("DAC output with no accepted sample behind it");
                end else begin
                    exp_val = dac_q.pop_front();
                    acc_cyc = cyc_q.pop_front();
                    if (longint'(m_dac.data) != exp_val) begin
                        value_error("m_dac", exp_val, m_dac.data);
                    end
                    // Exactly 2 cycles unless m_dac_ready dropped since acceptance
                    if (cyc - acc_cyc < 2 || (cyc - acc_cyc != 2 && last_dac_low <= acc_cyc)) begin
                        other_error($sformatf("DAC latency of %0d cycles, 2 expected",
                                              cyc - acc_cyc));
                    end
                end
            end
            mon_hold = m_mon_valid && !m_mon_ready;
            mon_held = m_mon.data;
            dac_hold = m_dac_valid && !m_dac_ready;
            dac_held = m_dac.data;
            if (!m_dac_ready) begin
                last_dac_low = cyc;
            end
        end
        reset_d = reset;
        n_pending = mon_q.size() + dac_q.size();
    end

endmodule

// ==== rtl/dsp_chain_top.sv ====
`timescale 1ns/1ps

module dsp_chain_top (
    input  logic                  a_clk,
    input  logic                  reset,
    // ADC sample stream
    input  dsp_pkg::adc_stream_t  s_adc,
    input  logic                  s_adc_valid,
    output logic                  s_adc_ready,
    // Monitor capture, widened raw samples
    output dsp_pkg::lane_stream_t m_mon,
    output logic                  m_mon_valid,
    input  logic                  m_mon_ready,
    // Filtered DAC samples
    output dsp_pkg::dac_stream_t  m_dac,
    output logic                  m_dac_valid,
    input  logic                  m_dac_ready
);

    import dsp_pkg::*;

    // Splitter to FIR
    lane_stream_t fir_in;
    logic         fir_in_valid;
    logic         fir_in_ready;

    // FIR to rounding stage
    acc_stream_t  acc;
    logic         acc_valid;
    logic         acc_ready;

    ////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////

    // Broadcast, 0 cycles
    axis_splitter #(
        .ADC_WIDTH  (ADC_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_splitter (
        .s_adc       (s_adc),
        .s_adc_valid (s_adc_valid),
        .s_adc_ready (s_adc_ready),
        .m_mon       (m_mon),
        .m_mon_valid (m_mon_valid),
        .m_mon_ready (m_mon_ready),
        .m_fir       (fir_in),
        .m_fir_valid (fir_in_valid),
        .m_fir_ready (fir_in_ready)
    );

    // FIR, 1 cycle
    axis_fir #(
        .DATA_WIDTH (DATA_WIDTH),
        .ACC_WIDTH  (ACC_WIDTH),
        .NUM_TAPS   (NUM_TAPS)
    ) u_fir (
        .a_clk        (a_clk),
        .reset        (reset),
        .s_lane       (fir_in),
        .s_lane_valid (fir_in_valid),
        .s_lane_ready (fir_in_ready),
        .m_acc        (acc),
        .m_acc_valid  (acc_valid),
        .m_acc_ready  (acc_ready)
    );

    // Round and saturate, 1 cycle
    axis_dac_round #(
        .ACC_WIDTH (ACC_WIDTH),
        .DAC_WIDTH (DAC_WIDTH),
        .COEF_FRAC (COEF_FRAC)
    ) u_round (
        .a_clk       (a_clk),
        .reset       (reset),
        .s_acc       (acc),
        .s_acc_valid (acc_valid),
        .s_acc_ready (acc_ready),
        .m_dac       (m_dac),
        .m_dac_valid (m_dac_valid),
        .m_dac_ready (m_dac_ready)
    );

endmodule

// ==== rtl/axis_dac_round.sv ====
`timescale 1ns/1ps

module axis_dac_round #(
    parameter int ACC_WIDTH = 36,
    parameter int DAC_WIDTH = 14,
    parameter int COEF_FRAC = 15
) (
    input  logic                 a_clk,
    input  logic                 reset,
    // Accumulator input
    input  dsp_pkg::acc_stream_t s_acc,
    input  logic                 s_acc_valid,
    output logic                 s_acc_ready,
    // DAC output
    output dsp_pkg::dac_stream_t m_dac,
    output logic                 m_dac_valid,
    input  logic                 m_dac_ready
);

    import dsp_pkg::*;

    // Lane bits dropped to reach DAC width
    localparam int LANE_SHIFT = DATA_WIDTH - DAC_WIDTH;

    // Bias added to negatives before the arithmetic shift
    localparam logic signed [ACC_WIDTH-1:0] FRAC_MASK = (ACC_WIDTH'(1) <<< COEF_FRAC) - 1;
    localparam logic signed [ACC_WIDTH-1:0] LANE_MASK = (ACC_WIDTH'(1) <<< LANE_SHIFT) - 1;

    // Signed DAC range
    localparam logic signed [ACC_WIDTH-1:0] DAC_MAX = (ACC_WIDTH'(1) <<< (DAC_WIDTH - 1)) - 1;
    localparam logic signed [ACC_WIDTH-1:0] DAC_MIN = -DAC_MAX - 1;

    logic signed [ACC_WIDTH-1:0] bias_frac;
    logic signed [ACC_WIDTH-1:0] q_frac;
    logic signed [ACC_WIDTH-1:0] bias_lane;
    logic signed [ACC_WIDTH-1:0] q_lane;
    logic signed [ACC_WIDTH-1:0] sat;
    logic                        accept;

    ////////////////////////////////////////
    // Round toward zero
    ////////////////////////////////////////

    // Drop coefficient fraction
    // Plain >>> floors, the bias turns it into truncation for negatives
    always_comb begin
        bias_frac = s_acc.data[ACC_WIDTH-1] ? FRAC_MASK : '0;
        q_frac    = (s_acc.data + bias_frac) >>> COEF_FRAC;
        // Then lane width down to DAC width, same rule
        bias_lane = q_frac[ACC_WIDTH-1] ? LANE_MASK : '0;
        q_lane    = (q_frac + bias_lane) >>> LANE_SHIFT;
    end

    // Clamp
    always_comb begin
        if (q_lane > DAC_MAX) begin
            sat = DAC_MAX;
        end else if (q_lane < DAC_MIN) begin
            sat = DAC_MIN;
        end else begin
            sat = q_lane;
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    assign s_acc_ready = !m_dac_valid || m_dac_ready;
    assign accept      = s_acc_valid && s_acc_ready;

    always_ff @(posedge a_clk) begin
        if (reset) begin
            m_dac_valid <= 1'b0;
            m_dac.data  <= '0;
        end else if (accept) begin
            m_dac_valid <= 1'b1;
            // In range after the clamp, low bits carry the value
            m_dac.data  <= sat[DAC_WIDTH-1:0];
        end else if (m_dac_ready) begin
            m_dac_valid <= 1'b0;
        end
    end

endmodule

// ==== rtl/axis_fir.sv ====
`timescale 1ns/1ps

module axis_fir #(
    parameter int DATA_WIDTH = 16,
    parameter int ACC_WIDTH  = 36,
    parameter int NUM_TAPS   = 4
) (
    input  logic                  a_clk,
    input  logic                  reset,
    // Lane input
    input  dsp_pkg::lane_stream_t s_lane,
    input  logic                  s_lane_valid,
    output logic                  s_lane_ready,
    // Accumulator output
    output dsp_pkg::acc_stream_t  m_acc,
    output logic                  m_acc_valid,
    input  logic                  m_acc_ready
);

    import dsp_pkg::*;

    // Signed sample times signed coefficient
    localparam int PROD_WIDTH = DATA_WIDTH + COEF_WIDTH;

    // Past samples, index 0 is the most recent accepted one
    logic signed [DATA_WIDTH-1:0] dly [NUM_TAPS-1];
    // Full tap window, incoming sample plus history
    logic signed [DATA_WIDTH-1:0] win [NUM_TAPS];
    logic signed [PROD_WIDTH-1:0] prod [NUM_TAPS];
    logic signed [ACC_WIDTH-1:0]  acc_sum;
    logic                         accept;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Output register empty or draining this cycle
    assign s_lane_ready = !m_acc_valid || m_acc_ready;
    assign accept       = s_lane_valid && s_lane_ready;

    ////////////////////////////////////////
    // Tap window and MAC
    ////////////////////////////////////////

    // Newest sample on tap 0, older ones follow
    always_comb begin
        win[0] = s_lane.data;
        for (int i = 1; i < NUM_TAPS; i++) begin
            win[i] = dly[i-1];
        end
    end

    // Sum of products, full precision
    always_comb begin
        acc_sum = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod[i] = win[i] * fir_coefs[i];
            // Sign extend product into accumulator
            acc_sum = acc_sum + ACC_WIDTH'(prod[i]);
        end
    end

    ////////////////////////////////////////
    // Delay line
    ////////////////////////////////////////

    // Advances on accepted samples only
    always_ff @(posedge a_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS - 1; i++) begin
                dly[i] <= '0;
            end
        end else if (accept) begin
            dly[0] <= s_lane.data;
            for (int i = 1; i < NUM_TAPS - 1; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    // One deep, valid one cycle after accept
    always_ff @(posedge a_clk) begin
        if (reset) begin
            m_acc_valid <= 1'b0;
            m_acc.data  <= '0;
        end else if (accept) begin
            m_acc_valid <= 1'b1;
            m_acc.data  <= acc_sum;
        end else if (m_acc_ready) begin
            // Drained with nothing new behind it
            m_acc_valid <= 1'b0;
        end
    end

endmodule

// ==== rtl/axis_splitter.sv ====
`timescale 1ns/1ps

module axis_splitter #(
    parameter int ADC_WIDTH  = 14,
    parameter int DATA_WIDTH = 16
) (
    // ADC input stream
    input  dsp_pkg::adc_stream_t  s_adc,
    input  logic                  s_adc_valid,
    output logic                  s_adc_ready,
    // Monitor branch
    output dsp_pkg::lane_stream_t m_mon,
    output logic                  m_mon_valid,
    input  logic                  m_mon_ready,
    // Filter branch
    output dsp_pkg::lane_stream_t m_fir,
    output logic                  m_fir_valid,
    input  logic                  m_fir_ready
);

    // Number of zero bits below the sample
    localparam int PAD_WIDTH = DATA_WIDTH - ADC_WIDTH;

    logic signed [DATA_WIDTH-1:0] widened;

    ////////////////////////////////////////
    // Expand
    ////////////////////////////////////////

    // Sample moves to the top of the lane
    // Sign bit lands on the lane MSB, so no extension needed
    assign widened = {s_adc.data, {PAD_WIDTH{1'b0}}};

    // Same payload to both branches
    assign m_mon.data = widened;
    assign m_fir.data = widened;

    ////////////////////////////////////////
    // Broadcast handshake
    ////////////////////////////////////////

    // Input only moves when both branches can take it
    assign s_adc_ready = m_mon_ready && m_fir_ready;

    // Each valid gated by the other branch's ready
    // Both transfer in the same cycle or neither does
    assign m_mon_valid = s_adc_valid && m_fir_ready;
    assign m_fir_valid = s_adc_valid && m_mon_ready;

endmodule

// ==== rtl/dsp_pkg.sv ====
package dsp_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Raw converter sample
    localparam int ADC_WIDTH  = 14;
    // Internal lane, ADC sample left-justified
    localparam int DATA_WIDTH = 16;
    // Full precision FIR sum
    localparam int ACC_WIDTH  = 36;
    localparam int DAC_WIDTH  = 14;

    ////////////////////////////////////////
    // FIR coefficients
    ////////////////////////////////////////

    localparam int NUM_TAPS   = 4;
    localparam int COEF_WIDTH = 16;
    // Q1.15 format
    localparam int COEF_FRAC  = 15;

    // 0.125, 0.375, 0.375, 0.125 (unity DC gain)
    localparam logic signed [COEF_WIDTH-1:0] fir_coefs [NUM_TAPS] = '{
        16'sd4096,
        16'sd12288,
        16'sd12288,
        16'sd4096
    };

    ////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic signed [ADC_WIDTH-1:0] data;
    } adc_stream_t;

    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] data;
    } lane_stream_t;

    typedef struct packed {
        logic signed [ACC_WIDTH-1:0] data;
    } acc_stream_t;

    typedef struct packed {
        logic signed [DAC_WIDTH-1:0] data;
    } dac_stream_t;

endpackage
